/* Makefile */
TOP = dcache_tb

all: run

build:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module dcache_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* bench/dcache_model.sv */
// reference model of the data cache, fed with the top-level strobes; queues expected load results
module dcache_model (
    input logic              clk,
    input logic              reset,
    input logic              l2_fill,
    input dcache_pkg::addr_t l2_addr,
    input dcache_pkg::line_t l2_line,
    input logic              mem_fill,
    input dcache_pkg::addr_t mem_addr,
    input dcache_pkg::line_t mem_line,
    input logic              cpu_req,
    input logic              cpu_we,
    input dcache_pkg::addr_t cpu_addr,
    input dcache_pkg::word_t cpu_wd
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    tag_t            tags [2][SETS];
    line_t           lines [2][SETS];
    logic [SETS-1:0] valid [2];
    logic [SETS-1:0] lru;                 // next way to evict
    logic            hit_q [$];           // expected results in load order
    word_t           data_q [$];
    int              edge_q [$];          // sampling edge of each load
    int              edges = 0;           // rising edges seen so far

    task automatic lookup(input addr_t a, output logic hit, output logic way);
        hit = valid[0][a[11:4]] && (tags[0][a[11:4]] == a[31:12]);
        way = 1'b0;                       // way 0 checked first
        if (!hit) begin
            hit = valid[1][a[11:4]] && (tags[1][a[11:4]] == a[31:12]);
            way = 1'b1;
        end
    endtask

    task automatic refill(input addr_t a, input line_t l);
        index_t i;
        logic   v;
        i = a[11:4];
        v = valid[0][i] ? (valid[1][i] ? lru[i] : 1'b1) : 1'b0;   // invalid way first
        tags[v][i]  = a[31:12];
        lines[v][i] = l;
        valid[v][i] = 1'b1;
        lru[i]      = ~v;
    endtask

    task automatic cpu_access(input addr_t a, input logic we, input word_t wd);
        logic hit;
        logic way;
        lookup(a, hit, way);
        if (hit) begin
            lru[a[11:4]] = ~way;
            if (we) lines[way][a[11:4]][a[3:2]*32 +: 32] = wd;
        end
        if (!we) begin                    // stores give no response
            hit_q.push_back(hit);
            data_q.push_back(hit ? lines[way][a[11:4]][a[3:2]*32 +: 32] : '0);
            edge_q.push_back(edges);
        end
    endtask

    always @(posedge clk) begin
        edges++;
        if (reset) begin
            valid[0] = '0;
            valid[1] = '0;
            lru      = '0;
        end else if (l2_fill) begin
            refill(l2_addr, l2_line);
        end else if (mem_fill) begin
            refill(mem_addr, mem_line);
        end else if (cpu_req) begin
            cpu_access(cpu_addr, cpu_we, cpu_wd);
        end
    end

    function automatic int pending();
        return hit_q.size();
    endfunction

    task automatic pop_expected(output logic hit, output word_t data, output int age);
        hit  = hit_q.pop_front();
        data = data_q.pop_front();
        age  = edges - edge_q.pop_front() + 1;   // counting the sampling edge
    endtask

endmodule

/* bench/dcache_tb.sv */
// testbench for the data cache top: directed and random traffic checked against the cache model
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 29;      // requests of tests 1 to 5
    localparam int RAND_CYCLES     = 400;
    localparam int LOAD_LATENCY    = 3;       // edges from load sample to response
    localparam int DRAIN_WAIT      = 4;       // max cycles waiting for the last response
    localparam int DRAIN_CYCLES    = 6 * (DRAIN_WAIT + 1);   // pipeline drain after each test
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES
                                     + DRAIN_CYCLES + 20;

    logic   clk = 1'b0;
    logic   reset;
    logic   l2_fill;
    addr_t  l2_addr;
    line_t  l2_line;
    logic   mem_fill;
    addr_t  mem_addr;
    line_t  mem_line;
    logic   cpu_req;
    logic   cpu_we;
    addr_t  cpu_addr;
    word_t  cpu_wd;
    logic   rsp_valid;
    logic   rsp_hit;
    word_t  rsp_data;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    int     mark_checks = 0;
    int     mark_errors = 0;
    tag_t   tag_pool [3] = '{20'h1_2345, 20'h0_abcd, 20'h7_7001};
    index_t index_pool [4] = '{8'h03, 8'h5a, 8'ha7, 8'hf0};

    dcache_top UUT (.*);
    dcache_model model (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_hit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // outputs are registered at the rising edge, so sample them at the falling one
    always @(negedge clk) begin : check_response
        logic  exp_hit;
        word_t exp_data;
        int    age;
        if (!reset && rsp_valid) begin
            if (model.pending() == 0) begin
                errors++;
                $display("error at %0t: response with no load outstanding", $time);
            end else begin
                model.pop_expected(exp_hit, exp_data, age);
                checks++;
                if (age != LOAD_LATENCY) begin
                    errors++;
                    $display("error at %0t: load answered %0d edges after its request, not %0d",
                             $time, age, LOAD_LATENCY);
                end
                check_hit("rsp_hit", rsp_hit, exp_hit);
                if (exp_hit) check_word("rsp_data", rsp_data, exp_data);
            end
        end
    end

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o, 2'b00};
    endfunction

    function automatic addr_t pool_addr();
        logic [31:0] r;
        r = $urandom();
        return make_addr(tag_pool[2'(r[7:0] % 8'd3)], index_pool[r[9:8]], r[11:10]);
    endfunction

    function automatic line_t random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // one cycle of strobes, applied on the falling edge
    task automatic drive(input logic l2, input addr_t la, input line_t ll,
                         input logic mf, input addr_t ma, input line_t ml,
                         input logic cr, input logic we, input addr_t ca, input word_t wd);
        @(negedge clk);
        l2_fill  = l2;
        l2_addr  = la;
        l2_line  = ll;
        mem_fill = mf;
        mem_addr = ma;
        mem_line = ml;
        cpu_req  = cr;
        cpu_we   = we;
        cpu_addr = ca;
        cpu_wd   = wd;
    endtask

    task automatic load(input addr_t a);
        drive(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, 1'b0, a, '0);
    endtask

    task automatic store(input addr_t a, input word_t d);
        drive(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, 1'b1, a, d);
    endtask

    task automatic fill_from_l2(input addr_t a, input line_t l);
        drive(1'b1, a, l, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic fill_from_mem(input addr_t a, input line_t l);
        drive(1'b0, '0, '0, 1'b1, a, l, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic end_test(input string name);
        int waited;
        drive(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
        waited = 0;
        while (model.pending() != 0 && waited < DRAIN_WAIT) begin
            @(posedge clk);
            waited++;
        end
        $display("%s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        void'($urandom(32'h0a8a_fb55));
        reset    = 1'b1;
        l2_fill  = 1'b0;
        l2_addr  = '0;
        l2_line  = '0;
        mem_fill = 1'b0;
        mem_addr = '0;
        mem_line = '0;
        cpu_req  = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_wd   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int n = 0; n < 4; n++) begin
            load(make_addr(tag_pool[0], index_pool[n[1:0]], offset_t'(n)));
        end
        end_test("test 1 load after reset");

        fill_from_l2(make_addr(tag_pool[0], index_pool[0], 2'd0), random_line());
        for (int n = 0; n < 4; n++) begin
            load(make_addr(tag_pool[0], index_pool[0], offset_t'(n)));
        end
        end_test("test 2 refill then loads");

        store(make_addr(tag_pool[0], index_pool[0], 2'd2), $urandom());
        for (int n = 0; n < 4; n++) begin
            load(make_addr(tag_pool[0], index_pool[0], offset_t'(n)));
        end
        store(make_addr(tag_pool[1], index_pool[0], 2'd1), $urandom());   // misses
        load(make_addr(tag_pool[1], index_pool[0], 2'd1));
        load(make_addr(tag_pool[0], index_pool[0], 2'd1));
        end_test("test 3 store hit and miss");

        // the load hit on tag 0 makes tag 1 the eviction choice
        fill_from_l2(make_addr(tag_pool[0], index_pool[1], 2'd0), random_line());
        fill_from_mem(make_addr(tag_pool[1], index_pool[1], 2'd0), random_line());
        load(make_addr(tag_pool[0], index_pool[1], 2'd1));
        fill_from_l2(make_addr(tag_pool[2], index_pool[1], 2'd0), random_line());
        load(make_addr(tag_pool[1], index_pool[1], 2'd2));
        load(make_addr(tag_pool[0], index_pool[1], 2'd3));
        load(make_addr(tag_pool[2], index_pool[1], 2'd0));
        end_test("test 4 lru eviction");

        drive(1'b1, make_addr(tag_pool[0], index_pool[2], 2'd0), random_line(),
              1'b1, make_addr(tag_pool[1], index_pool[2], 2'd0), random_line(),
              1'b1, 1'b0, make_addr(tag_pool[0], index_pool[3], 2'd0), '0);
        drive(1'b0, '0, '0,
              1'b1, make_addr(tag_pool[2], index_pool[3], 2'd0), random_line(),
              1'b1, 1'b1, make_addr(tag_pool[0], index_pool[2], 2'd0), 32'hdead_beef);
        load(make_addr(tag_pool[0], index_pool[2], 2'd0));
        load(make_addr(tag_pool[1], index_pool[2], 2'd1));
        load(make_addr(tag_pool[2], index_pool[3], 2'd3));
        end_test("test 5 priority of strobes");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            r = $urandom();
            drive(r[2:0] == 3'd0, pool_addr(), random_line(),
                  r[5:3] == 3'd0, pool_addr(), random_line(),
                  r[6], r[8:7] == 2'd0, pool_addr(), $urandom());
        end
        end_test("test 6 random traffic");

        if (model.pending() != 0) begin
            $display("error: %0d load responses never arrived", model.pending());
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && model.pending() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
source/dcache_pkg.sv
source/dcache_req_if.sv
source/dcache_way_if.sv
source/ram256x32.sv
source/dcache_arbiter.sv
source/dcache_tag_stage.sv
source/dcache_data_ram.sv
source/dcache_top.sv
bench/dcache_model.sv
bench/dcache_tb.sv

/* source/dcache_arbiter.sv */
// fixed-priority select of L2 refill, memory refill and CPU access into one registered request
module dcache_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              l2_fill,
    input  dcache_pkg::addr_t l2_addr,
    input  dcache_pkg::line_t l2_line,
    input  logic              mem_fill,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::line_t mem_line,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  dcache_pkg::addr_t cpu_addr,
    input  dcache_pkg::word_t cpu_wd,
    dcache_req_if.source      req
);
    import dcache_pkg::*;

    req_kind_t sel_kind;
    addr_t     sel_addr;
    line_t     sel_line;

    always_comb begin
        sel_kind = REQ_NONE;
        sel_addr = cpu_addr;
        sel_line = l2_line;
        if (l2_fill) begin                        // l2 wins everything
            sel_kind = REQ_FILL;
            sel_addr = l2_addr;
        end else if (mem_fill) begin
            sel_kind = REQ_FILL;
            sel_addr = mem_addr;
            sel_line = mem_line;
        end else if (cpu_req) begin
            sel_kind = cpu_we ? REQ_STORE : REQ_LOAD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req.kind <= REQ_NONE;
        end else begin
            req.kind <= sel_kind;
        end
    end

    always_ff @(posedge clk) begin
        req.tag    <= sel_addr[TAG_LSB +: TAG_W];
        req.index  <= sel_addr[INDEX_LSB +: INDEX_W];
        req.offset <= sel_addr[OFFSET_LSB +: OFFSET_W];
        req.wd     <= cpu_wd;
        req.line   <= sel_line;
    end

endmodule

/* source/dcache_data_ram.sv */
// data array of both ways: line and word write decode, eight banks and load word select
module dcache_data_ram (
    input  logic               clk,
    input  logic               reset,
    dcache_way_if.sink         acc,
    output logic               rsp_valid,
    output logic               rsp_hit,
    output dcache_pkg::word_t  rsp_data
);
    import dcache_pkg::*;

    line_t                 wdata;
    logic [LINE_WORDS-1:0] lane;
    logic [LINE_WORDS-1:0] we [2];          // per way, per bank
    logic                  rd_en;
    word_t                 rd_q [2][LINE_WORDS];

    logic                  hit_q;
    logic                  way_q;
    offset_t               offset_q;

    always_comb begin
        wdata = acc.line;
        lane  = '0;
        rd_en = 1'b0;
        case (acc.kind)
            REQ_FILL: begin
                lane = '1;                            // whole line
            end
            REQ_STORE: begin
                wdata[acc.offset*WORD_W +: WORD_W] = acc.wd;
                lane[acc.offset]                   = 1'b1;
            end
            REQ_LOAD: begin
                rd_en = 1'b1;                         // read both ways
            end
            default: begin
                lane = '0;
            end
        endcase
        we[0] = acc.way0_we ? lane : '0;
        we[1] = acc.way1_we ? lane : '0;
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
            ram256x32 u_bank (
                .clock   (clk),
                .address (acc.index),
                .wren    (we[w][b]),
                .rden    (rd_en),
                .data    (wdata[b*WORD_W +: WORD_W]),
                .q       (rd_q[w][b])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;                       // one pulse per load
        end
    end

    always_ff @(posedge clk) begin
        hit_q    <= acc.hit;
        way_q    <= acc.read_way;
        offset_q <= acc.offset;
    end

    assign rsp_hit  = hit_q;
    assign rsp_data = rd_q[way_q][offset_q];      // valid only on a hit

endmodule

/* source/dcache_pkg.sv */
// shared widths, data types and request kinds for the two-way data cache, imported by every stage
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;                    // words per line
    localparam int OFFSET_LSB = 2;                    // word aligned
    localparam int OFFSET_W   = 2;
    localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
    localparam int INDEX_W    = 8;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;
    localparam int TAG_W      = ADDR_W - TAG_LSB;     // 20 bits
    localparam int SETS       = 2 ** INDEX_W;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [WORD_W*LINE_WORDS-1:0] line_t;   // word 0 in the low bits

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_LOAD,
        REQ_STORE,
        REQ_FILL
    } req_kind_t;

endpackage

/* source/dcache_req_if.sv */
// arbitrated request bundle, driven by the arbiter and read by the tag stage
interface dcache_req_if;
    import dcache_pkg::*;

    req_kind_t kind;     // valid for the cycle it is present
    tag_t      tag;
    index_t    index;
    offset_t   offset;
    word_t     wd;       // store word
    line_t     line;     // refill line

    modport source (
        output kind, tag, index, offset, wd, line
    );

    modport sink (
        input kind, tag, index, offset, wd, line
    );

endinterface

/* source/dcache_tag_stage.sv */
// tag, valid and LRU state of both ways; resolves hit and victim way for each request
module dcache_tag_stage (
    input  logic          clk,
    input  logic          reset,
    dcache_req_if.sink    req,
    dcache_way_if.source  acc
);
    import dcache_pkg::*;

    tag_t            tag0 [SETS];
    tag_t            tag1 [SETS];
    logic [SETS-1:0] valid0;
    logic [SETS-1:0] valid1;
    logic [SETS-1:0] lru;       // way to evict next

    logic hit0;
    logic hit1;
    logic hit;
    logic hit_way;
    logic victim;
    logic use_way;
    logic we0;
    logic we1;
    logic touch;

    always_comb begin
        hit0    = valid0[req.index] && (tag0[req.index] == req.tag);
        hit1    = valid1[req.index] && (tag1[req.index] == req.tag);
        hit     = hit0 | hit1;
        hit_way = ~hit0;                          // way 0 preferred on a double match

        // invalid way first, then lru
        if (!valid0[req.index]) begin
            victim = 1'b0;
        end else if (!valid1[req.index]) begin
            victim = 1'b1;
        end else begin
            victim = lru[req.index];
        end

        use_way = hit_way;
        we0     = 1'b0;
        we1     = 1'b0;
        touch   = 1'b0;
        case (req.kind)
            REQ_FILL: begin
                use_way = victim;
                we0     = ~victim;
                we1     = victim;
                touch   = 1'b1;
            end
            REQ_STORE: begin
                we0   = hit & ~hit_way;               // no allocate on a miss
                we1   = hit & hit_way;
                touch = hit;
            end
            REQ_LOAD: begin
                touch = hit;
            end
            default: begin
                touch = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req.kind == REQ_FILL) begin
            if (victim) begin
                tag1[req.index] <= req.tag;
            end else begin
                tag0[req.index] <= req.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid0      <= '0;
            valid1      <= '0;
            lru         <= '0;
            acc.kind    <= REQ_NONE;
            acc.way0_we <= 1'b0;
            acc.way1_we <= 1'b0;
        end else begin
            if (we0 && req.kind == REQ_FILL) valid0[req.index] <= 1'b1;
            if (we1 && req.kind == REQ_FILL) valid1[req.index] <= 1'b1;
            if (touch) lru[req.index] <= ~use_way;    // point away from the used way
            acc.kind    <= req.kind;
            acc.way0_we <= we0;
            acc.way1_we <= we1;
        end
    end

    always_ff @(posedge clk) begin
        acc.index    <= req.index;
        acc.offset   <= req.offset;
        acc.wd       <= req.wd;
        acc.line     <= req.line;
        acc.read_way <= hit_way;
        acc.hit      <= hit;
    end

endmodule

/* source/dcache_top.sv */
// top of the data cache: arbiter, tag stage and data RAM joined by two bundles
module dcache_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              l2_fill,
    input  dcache_pkg::addr_t l2_addr,
    input  dcache_pkg::line_t l2_line,
    input  logic              mem_fill,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::line_t mem_line,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  dcache_pkg::addr_t cpu_addr,
    input  dcache_pkg::word_t cpu_wd,
    output logic              rsp_valid,
    output logic              rsp_hit,
    output dcache_pkg::word_t rsp_data
);

    dcache_req_if req_bus ();    // arbiter to tag stage
    dcache_way_if acc_bus ();    // tag stage to data ram

    dcache_arbiter u_arbiter (
        .clk      (clk),
        .reset    (reset),
        .l2_fill  (l2_fill),
        .l2_addr  (l2_addr),
        .l2_line  (l2_line),
        .mem_fill (mem_fill),
        .mem_addr (mem_addr),
        .mem_line (mem_line),
        .cpu_req  (cpu_req),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_wd   (cpu_wd),
        .req      (req_bus.source)
    );

    dcache_tag_stage u_tag_stage (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.sink),
        .acc   (acc_bus.source)
    );

    dcache_data_ram u_data_ram (
        .clk       (clk),
        .reset     (reset),
        .acc       (acc_bus.sink),
        .rsp_valid (rsp_valid),
        .rsp_hit   (rsp_hit),
        .rsp_data  (rsp_data)
    );

endmodule

/* source/dcache_way_if.sv */
// resolved access bundle, driven by the tag stage and read by the data RAM stage
interface dcache_way_if;
    import dcache_pkg::*;

    req_kind_t kind;
    index_t    index;
    offset_t   offset;
    word_t     wd;
    line_t     line;
    logic      way0_we;    // write strobe of way 0
    logic      way1_we;    // write strobe of way 1
    logic      read_way;   // hit way for loads
    logic      hit;

    modport source (
        output kind, index, offset, wd, line, way0_we, way1_we, read_way, hit
    );

    modport sink (
        input kind, index, offset, wd, line, way0_we, way1_we, read_way, hit
    );

endinterface

/* source/ram256x32.sv */
// single-port 256x32 data bank with synchronous write and registered, enabled read
module ram256x32 (
    input  logic               clock,
    input  dcache_pkg::index_t address,
    input  logic               wren,
    input  logic               rden,
    input  dcache_pkg::word_t  data,
    output dcache_pkg::word_t  q
);
    import dcache_pkg::*;

    word_t mem [SETS];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[address] <= data;
        end
        if (rden) begin
            q <= mem[address];                    // holds when rden is low
        end
    end

endmodule
